// File: include/ooo_defines.svh
`ifndef OOO_DEFINES_SVH
`define OOO_DEFINES_SVH

// Architectural register file
`define GPR_WIDTH 32
`define GPR_IDX_WIDTH 3

// Reorder buffer
`define ROB_SIZE 8
`define ROB_IDX_WIDTH 3

// Reservation station depth
`define RS_SIZE 4

// MOVI immediate
`define IMM_WIDTH 16

`endif

// File: verilog/ooo_pkg.sv
`include "ooo_defines.svh"

package ooo_pkg;

    typedef enum logic [2:0] {
        MOVI,
        ADD,
        SUB,
        AND,
        ORR
    } alu_op_t;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } nzcv_t;

    typedef enum logic {
        IDLE,
        ACK_HIGH
    } dispatch_state_t;

    typedef struct packed {
        logic                      busy;
        logic                      ready;
        logic [`GPR_IDX_WIDTH-1:0] gpr_idx;
        logic [`GPR_WIDTH-1:0]     value;
        logic                      set_nzcv;
        nzcv_t                     nzcv;
    } rob_entry_t;

    // Operands carry a tag until their value arrives
    typedef struct packed {
        logic                      busy;
        alu_op_t                   op;
        logic                      set_nzcv;
        logic                      op1_ready;
        logic [`ROB_IDX_WIDTH-1:0] op1_tag;
        logic [`GPR_WIDTH-1:0]     op1_value;
        logic                      op2_ready;
        logic [`ROB_IDX_WIDTH-1:0] op2_tag;
        logic [`GPR_WIDTH-1:0]     op2_value;
        logic [`ROB_IDX_WIDTH-1:0] rob_idx;
    } rs_entry_t;

endpackage

// File: verilog/dispatch.sv
`timescale 1ns/1ps
`include "ooo_defines.svh"

module dispatch (
    input  logic                      in_clk,
    input  logic                      in_rst,
    input  logic                      instr_req,
    input  ooo_pkg::alu_op_t          instr_op,
    input  logic [`GPR_IDX_WIDTH-1:0] instr_dst,
    input  logic [`GPR_IDX_WIDTH-1:0] instr_src1,
    input  logic [`GPR_IDX_WIDTH-1:0] instr_src2,
    input  logic [`IMM_WIDTH-1:0]     instr_imm,
    input  logic                      instr_set_nzcv,
    input  logic [`ROB_IDX_WIDTH-1:0] rob_tail_idx,
    input  logic                      rob_full,
    input  logic                      rs_full,
    input  logic [`GPR_WIDTH-1:0]     src1_value,
    input  logic                      src1_busy,
    input  logic [`ROB_IDX_WIDTH-1:0] src1_tag,
    input  logic [`GPR_WIDTH-1:0]     src2_value,
    input  logic                      src2_busy,
    input  logic [`ROB_IDX_WIDTH-1:0] src2_tag,
    input  logic                      bypass1_ready,
    input  logic [`GPR_WIDTH-1:0]     bypass1_value,
    input  logic                      bypass2_ready,
    input  logic [`GPR_WIDTH-1:0]     bypass2_value,
    input  logic                      cdb_valid,
    input  logic [`ROB_IDX_WIDTH-1:0] cdb_rob_idx,
    input  logic [`GPR_WIDTH-1:0]     cdb_value,
    output logic                      instr_ack,
    output logic                      alloc_valid,
    output logic [`GPR_IDX_WIDTH-1:0] alloc_gpr_idx,
    output logic                      alloc_set_nzcv,
    output ooo_pkg::alu_op_t          rs_alloc_op,
    output logic                      rs_alloc_op1_ready,
    output logic [`ROB_IDX_WIDTH-1:0] rs_alloc_op1_tag,
    output logic [`GPR_WIDTH-1:0]     rs_alloc_op1_value,
    output logic                      rs_alloc_op2_ready,
    output logic [`ROB_IDX_WIDTH-1:0] rs_alloc_op2_tag,
    output logic [`GPR_WIDTH-1:0]     rs_alloc_op2_value,
    output logic                      rename_we,
    output logic [`GPR_IDX_WIDTH-1:0] rename_idx
);
    import ooo_pkg::*;

    dispatch_state_t       state;
    logic [`GPR_WIDTH:0]   src1_res;
    logic [`GPR_WIDTH:0]   src2_res;
    logic [`GPR_WIDTH-1:0] imm_ext;

    // Returns {ready, value}: register, then ROB, then this cycle's CDB
    function automatic logic [`GPR_WIDTH:0] resolve_src(
        input logic                      busy,
        input logic [`ROB_IDX_WIDTH-1:0] tag,
        input logic [`GPR_WIDTH-1:0]     reg_value,
        input logic                      byp_ready,
        input logic [`GPR_WIDTH-1:0]     byp_value
    );
        if (!busy)
            return {1'b1, reg_value};
        if (byp_ready)
            return {1'b1, byp_value};
        if (cdb_valid && cdb_rob_idx == tag)
            return {1'b1, cdb_value};
        return {1'b0, reg_value};
    endfunction

    assign imm_ext = {{(`GPR_WIDTH - `IMM_WIDTH){1'b0}}, instr_imm};

    always_comb begin
        if (instr_op == MOVI) begin
            src1_res = {1'b1, imm_ext};
            src2_res = {1'b1, {`GPR_WIDTH{1'b0}}};
        end else begin
            src1_res = resolve_src(src1_busy, src1_tag, src1_value, bypass1_ready, bypass1_value);
            src2_res = resolve_src(src2_busy, src2_tag, src2_value, bypass2_ready, bypass2_value);
        end
    end

    // Allocate once per request, only while both queues have room
    assign alloc_valid = (state == IDLE) && instr_req && !rob_full && !rs_full;
    assign instr_ack   = (state == ACK_HIGH);

    always_ff @(posedge in_clk) begin
        if (in_rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:     if (alloc_valid) state <= ACK_HIGH;
                ACK_HIGH: if (!instr_req) state <= IDLE;
                default:  state <= IDLE;
            endcase
        end
    end

    assign alloc_gpr_idx      = instr_dst;
    assign alloc_set_nzcv     = instr_set_nzcv;
    assign rename_we          = alloc_valid;
    assign rename_idx         = instr_dst;
    assign rs_alloc_op        = instr_op;
    assign rs_alloc_op1_ready = src1_res[`GPR_WIDTH];
    assign rs_alloc_op1_value = src1_res[`GPR_WIDTH-1:0];
    assign rs_alloc_op1_tag   = src1_tag;
    assign rs_alloc_op2_ready = src2_res[`GPR_WIDTH];
    assign rs_alloc_op2_value = src2_res[`GPR_WIDTH-1:0];
    assign rs_alloc_op2_tag   = src2_tag;

endmodule

// File: verilog/reservation_station.sv
`timescale 1ns/1ps
`include "ooo_defines.svh"

module reservation_station (
    input  logic                      in_clk,
    input  logic                      in_rst,
    input  logic                      alloc_valid,
    input  logic                      alloc_set_nzcv,
    input  logic [`ROB_IDX_WIDTH-1:0] rob_tail_idx,
    input  ooo_pkg::alu_op_t          rs_alloc_op,
    input  logic                      rs_alloc_op1_ready,
    input  logic [`ROB_IDX_WIDTH-1:0] rs_alloc_op1_tag,
    input  logic [`GPR_WIDTH-1:0]     rs_alloc_op1_value,
    input  logic                      rs_alloc_op2_ready,
    input  logic [`ROB_IDX_WIDTH-1:0] rs_alloc_op2_tag,
    input  logic [`GPR_WIDTH-1:0]     rs_alloc_op2_value,
    input  logic                      cdb_valid,
    input  logic [`ROB_IDX_WIDTH-1:0] cdb_rob_idx,
    input  logic [`GPR_WIDTH-1:0]     cdb_value,
    output logic                      rs_full,
    output logic                      issue_valid,
    output ooo_pkg::alu_op_t          issue_op,
    output logic [`GPR_WIDTH-1:0]     issue_a,
    output logic [`GPR_WIDTH-1:0]     issue_b,
    output logic                      issue_set_nzcv,
    output logic [`ROB_IDX_WIDTH-1:0] issue_rob_idx
);
    import ooo_pkg::*;

    localparam int SLOT_W = $clog2(`RS_SIZE);

    rs_entry_t         rs [`RS_SIZE];
    logic              free_found;
    logic [SLOT_W-1:0] free_slot;
    logic [SLOT_W-1:0] issue_slot;

    // Lowest free slot and lowest ready slot
    always_comb begin
        free_found  = 1'b0;
        free_slot   = '0;
        issue_valid = 1'b0;
        issue_slot  = '0;
        for (int i = `RS_SIZE - 1; i >= 0; i--) begin
            if (!rs[i].busy) begin
                free_found = 1'b1;
                free_slot  = i[SLOT_W-1:0];
            end
            if (rs[i].busy && rs[i].op1_ready && rs[i].op2_ready) begin
                issue_valid = 1'b1;
                issue_slot  = i[SLOT_W-1:0];
            end
        end
    end

    assign rs_full        = !free_found;
    assign issue_op       = rs[issue_slot].op;
    assign issue_a        = rs[issue_slot].op1_value;
    assign issue_b        = rs[issue_slot].op2_value;
    assign issue_set_nzcv = rs[issue_slot].set_nzcv;
    assign issue_rob_idx  = rs[issue_slot].rob_idx;

    always_ff @(posedge in_clk) begin
        if (in_rst) begin
            for (int i = 0; i < `RS_SIZE; i++)
                rs[i].busy <= 1'b0;
        end else begin
            // CDB wakeup of waiting operands
            for (int i = 0; i < `RS_SIZE; i++) begin
                if (cdb_valid && rs[i].busy) begin
                    if (!rs[i].op1_ready && rs[i].op1_tag == cdb_rob_idx) begin
                        rs[i].op1_ready <= 1'b1;
                        rs[i].op1_value <= cdb_value;
                    end
                    if (!rs[i].op2_ready && rs[i].op2_tag == cdb_rob_idx) begin
                        rs[i].op2_ready <= 1'b1;
                        rs[i].op2_value <= cdb_value;
                    end
                end
            end
            if (issue_valid)
                rs[issue_slot].busy <= 1'b0;
            if (alloc_valid) begin
                rs[free_slot] <= '{busy:      1'b1,
                                   op:        rs_alloc_op,
                                   set_nzcv:  alloc_set_nzcv,
                                   op1_ready: rs_alloc_op1_ready,
                                   op1_tag:   rs_alloc_op1_tag,
                                   op1_value: rs_alloc_op1_value,
                                   op2_ready: rs_alloc_op2_ready,
                                   op2_tag:   rs_alloc_op2_tag,
                                   op2_value: rs_alloc_op2_value,
                                   rob_idx:   rob_tail_idx};
            end
        end
    end

endmodule

// File: verilog/alu_unit.sv
`timescale 1ns/1ps
`include "ooo_defines.svh"

module alu_unit (
    input  logic                      in_clk,
    input  logic                      in_rst,
    input  logic                      issue_valid,
    input  ooo_pkg::alu_op_t          issue_op,
    input  logic [`GPR_WIDTH-1:0]     issue_a,
    input  logic [`GPR_WIDTH-1:0]     issue_b,
    input  logic                      issue_set_nzcv,
    input  logic [`ROB_IDX_WIDTH-1:0] issue_rob_idx,
    output logic                      cdb_valid,
    output logic [`ROB_IDX_WIDTH-1:0] cdb_rob_idx,
    output logic [`GPR_WIDTH-1:0]     cdb_value,
    output logic                      cdb_set_nzcv,
    output ooo_pkg::nzcv_t            cdb_nzcv
);
    import ooo_pkg::*;

    localparam int MSB = `GPR_WIDTH - 1;

    logic [`GPR_WIDTH-1:0] result;
    logic                  carry;
    logic                  overflow;

    always_comb begin
        carry    = 1'b0;
        overflow = 1'b0;
        case (issue_op)
            ADD: begin
                {carry, result} = {1'b0, issue_a} + {1'b0, issue_b};
                overflow = (issue_a[MSB] == issue_b[MSB]) && (result[MSB] != issue_a[MSB]);
            end
            SUB: begin
                // Carry is the inverted borrow
                {carry, result} = {1'b0, issue_a} + {1'b0, ~issue_b} + 1'b1;
                overflow = (issue_a[MSB] != issue_b[MSB]) && (result[MSB] != issue_a[MSB]);
            end
            AND:     result = issue_a & issue_b;
            ORR:     result = issue_a | issue_b;
            default: result = issue_a;
        endcase
    end

    always_ff @(posedge in_clk) begin
        if (in_rst)
            cdb_valid <= 1'b0;
        else
            cdb_valid <= issue_valid;
    end

    always_ff @(posedge in_clk) begin
        cdb_rob_idx  <= issue_rob_idx;
        cdb_value    <= result;
        cdb_set_nzcv <= issue_set_nzcv;
        cdb_nzcv     <= '{n: result[MSB], z: (result == '0), c: carry, v: overflow};
    end

endmodule

// File: verilog/rob.sv
`timescale 1ns/1ps
`include "ooo_defines.svh"

module rob (
    input  logic                      in_clk,
    input  logic                      in_rst,
    input  logic                      alloc_valid,
    input  logic [`GPR_IDX_WIDTH-1:0] alloc_gpr_idx,
    input  logic                      alloc_set_nzcv,
    input  logic [`ROB_IDX_WIDTH-1:0] bypass1_idx,
    input  logic [`ROB_IDX_WIDTH-1:0] bypass2_idx,
    input  logic                      cdb_valid,
    input  logic [`ROB_IDX_WIDTH-1:0] cdb_rob_idx,
    input  logic [`GPR_WIDTH-1:0]     cdb_value,
    input  logic                      cdb_set_nzcv,
    input  ooo_pkg::nzcv_t            cdb_nzcv,
    output logic [`ROB_IDX_WIDTH-1:0] rob_tail_idx,
    output logic                      rob_full,
    output logic                      bypass1_ready,
    output logic [`GPR_WIDTH-1:0]     bypass1_value,
    output logic                      bypass2_ready,
    output logic [`GPR_WIDTH-1:0]     bypass2_value,
    output logic                      commit_valid,
    output logic [`ROB_IDX_WIDTH-1:0] commit_rob_idx,
    output logic [`GPR_IDX_WIDTH-1:0] commit_gpr_idx,
    output logic [`GPR_WIDTH-1:0]     commit_value,
    output logic                      commit_nzcv_valid,
    output ooo_pkg::nzcv_t            commit_nzcv
);
    import ooo_pkg::*;

    rob_entry_t                rob_q [`ROB_SIZE];
    logic [`ROB_IDX_WIDTH-1:0] head;
    logic [`ROB_IDX_WIDTH-1:0] tail;
    logic [`ROB_IDX_WIDTH:0]   count;

    assign rob_tail_idx = tail;
    assign rob_full     = (count == `ROB_SIZE);

    // Bypass only finished, uncommitted results
    assign bypass1_ready = rob_q[bypass1_idx].busy && rob_q[bypass1_idx].ready;
    assign bypass1_value = rob_q[bypass1_idx].value;
    assign bypass2_ready = rob_q[bypass2_idx].busy && rob_q[bypass2_idx].ready;
    assign bypass2_value = rob_q[bypass2_idx].value;

    // Head retires as soon as it is ready
    assign commit_valid      = rob_q[head].busy && rob_q[head].ready;
    assign commit_rob_idx    = head;
    assign commit_gpr_idx    = rob_q[head].gpr_idx;
    assign commit_value      = rob_q[head].value;
    assign commit_nzcv_valid = rob_q[head].set_nzcv;
    assign commit_nzcv       = rob_q[head].nzcv;

    always_ff @(posedge in_clk) begin
        if (in_rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < `ROB_SIZE; i++) begin
                rob_q[i].busy  <= 1'b0;
                rob_q[i].ready <= 1'b0;
            end
        end else begin
            if (commit_valid) begin
                rob_q[head].busy <= 1'b0;
                head <= head + 1'b1;
            end
            if (cdb_valid) begin
                rob_q[cdb_rob_idx].ready <= 1'b1;
                rob_q[cdb_rob_idx].value <= cdb_value;
                if (cdb_set_nzcv)
                    rob_q[cdb_rob_idx].nzcv <= cdb_nzcv;
            end
            if (alloc_valid) begin
                rob_q[tail] <= '{busy:     1'b1,
                                 ready:    1'b0,
                                 gpr_idx:  alloc_gpr_idx,
                                 value:    '0,
                                 set_nzcv: alloc_set_nzcv,
                                 nzcv:     '0};
                tail <= tail + 1'b1;
            end
            count <= count + alloc_valid - commit_valid;
        end
    end

endmodule

// File: verilog/regfile.sv
`timescale 1ns/1ps
`include "ooo_defines.svh"

module regfile (
    input  logic                      in_clk,
    input  logic                      in_rst,
    input  logic [`GPR_IDX_WIDTH-1:0] src1_idx,
    input  logic [`GPR_IDX_WIDTH-1:0] src2_idx,
    input  logic                      rename_we,
    input  logic [`GPR_IDX_WIDTH-1:0] rename_idx,
    input  logic [`ROB_IDX_WIDTH-1:0] rob_tail_idx,
    input  logic                      commit_valid,
    input  logic [`ROB_IDX_WIDTH-1:0] commit_rob_idx,
    input  logic [`GPR_IDX_WIDTH-1:0] commit_gpr_idx,
    input  logic [`GPR_WIDTH-1:0]     commit_value,
    output logic [`GPR_WIDTH-1:0]     src1_value,
    output logic                      src1_busy,
    output logic [`ROB_IDX_WIDTH-1:0] src1_tag,
    output logic [`GPR_WIDTH-1:0]     src2_value,
    output logic                      src2_busy,
    output logic [`ROB_IDX_WIDTH-1:0] src2_tag
);
    localparam int NUM_GPR = 1 << `GPR_IDX_WIDTH;

    logic [`GPR_WIDTH-1:0]     value [NUM_GPR];
    logic                      busy  [NUM_GPR];
    logic [`ROB_IDX_WIDTH-1:0] tag   [NUM_GPR];

    assign src1_value = value[src1_idx];
    assign src1_busy  = busy[src1_idx];
    assign src1_tag   = tag[src1_idx];
    assign src2_value = value[src2_idx];
    assign src2_busy  = busy[src2_idx];
    assign src2_tag   = tag[src2_idx];

    always_ff @(posedge in_clk) begin
        if (in_rst) begin
            for (int i = 0; i < NUM_GPR; i++) begin
                value[i] <= '0;
                busy[i]  <= 1'b0;
                tag[i]   <= '0;
            end
        end else begin
            if (commit_valid) begin
                value[commit_gpr_idx] <= commit_value;
                // A younger rename keeps the register busy
                if (busy[commit_gpr_idx] && tag[commit_gpr_idx] == commit_rob_idx)
                    busy[commit_gpr_idx] <= 1'b0;
            end
            if (rename_we) begin
                busy[rename_idx] <= 1'b1;
                tag[rename_idx]  <= rob_tail_idx;
            end
        end
    end

endmodule

// File: verilog/ooo_core.sv
`timescale 1ns/1ps
`include "ooo_defines.svh"

module ooo_core (
    input  logic                      in_clk,
    input  logic                      in_rst,
    input  logic                      instr_req,
    input  ooo_pkg::alu_op_t          instr_op,
    input  logic [`GPR_IDX_WIDTH-1:0] instr_dst,
    input  logic [`GPR_IDX_WIDTH-1:0] instr_src1,
    input  logic [`GPR_IDX_WIDTH-1:0] instr_src2,
    input  logic [`IMM_WIDTH-1:0]     instr_imm,
    input  logic                      instr_set_nzcv,
    output logic                      instr_ack,
    output logic                      commit_valid,
    output logic [`GPR_IDX_WIDTH-1:0] commit_gpr_idx,
    output logic [`GPR_WIDTH-1:0]     commit_value,
    output logic                      commit_nzcv_valid,
    output ooo_pkg::nzcv_t            commit_nzcv
);
    import ooo_pkg::*;

    logic                      alloc_valid;
    logic [`GPR_IDX_WIDTH-1:0] alloc_gpr_idx;
    logic                      alloc_set_nzcv;
    logic [`ROB_IDX_WIDTH-1:0] rob_tail_idx;
    logic                      rob_full;
    logic                      rs_full;
    alu_op_t                   rs_alloc_op;
    logic                      rs_alloc_op1_ready;
    logic                      rs_alloc_op2_ready;
    logic [`ROB_IDX_WIDTH-1:0] rs_alloc_op1_tag;
    logic [`ROB_IDX_WIDTH-1:0] rs_alloc_op2_tag;
    logic [`GPR_WIDTH-1:0]     rs_alloc_op1_value;
    logic [`GPR_WIDTH-1:0]     rs_alloc_op2_value;
    logic                      rename_we;
    logic [`GPR_IDX_WIDTH-1:0] rename_idx;
    logic [`GPR_WIDTH-1:0]     src1_value;
    logic [`GPR_WIDTH-1:0]     src2_value;
    logic                      src1_busy;
    logic                      src2_busy;
    logic [`ROB_IDX_WIDTH-1:0] src1_tag;
    logic [`ROB_IDX_WIDTH-1:0] src2_tag;
    logic                      bypass1_ready;
    logic                      bypass2_ready;
    logic [`GPR_WIDTH-1:0]     bypass1_value;
    logic [`GPR_WIDTH-1:0]     bypass2_value;
    logic                      issue_valid;
    alu_op_t                   issue_op;
    logic [`GPR_WIDTH-1:0]     issue_a;
    logic [`GPR_WIDTH-1:0]     issue_b;
    logic                      issue_set_nzcv;
    logic [`ROB_IDX_WIDTH-1:0] issue_rob_idx;
    logic                      cdb_valid;
    logic [`ROB_IDX_WIDTH-1:0] cdb_rob_idx;
    logic [`GPR_WIDTH-1:0]     cdb_value;
    logic                      cdb_set_nzcv;
    nzcv_t                     cdb_nzcv;
    logic [`ROB_IDX_WIDTH-1:0] commit_rob_idx;

    dispatch u_dispatch (.*);

    reservation_station u_rs (.*);

    alu_unit u_alu (.*);

    // Bypass ports look up the rename tags read from the register file
    rob u_rob (
        .bypass1_idx (src1_tag),
        .bypass2_idx (src2_tag),
        .*
    );

    regfile u_regfile (
        .src1_idx (instr_src1),
        .src2_idx (instr_src2),
        .*
    );

endmodule

// File: testbench/ooo_core_chk.sv
`timescale 1ns/1ps

module ooo_core_chk (
    input logic in_clk,
    input logic in_rst,
    input logic instr_req,
    input logic instr_ack,
    input logic commit_valid
);

    // Ack only answers a pending request
    ack_rise_needs_req: assert property (@(posedge in_clk) disable iff (in_rst)
        $rose(instr_ack) |-> $past(instr_req))
        else $error("instr_ack rose while instr_req was low");

    // Ack holds until the request is withdrawn
    ack_fall_needs_no_req: assert property (@(posedge in_clk) disable iff (in_rst)
        $fell(instr_ack) |-> !$past(instr_req))
        else $error("instr_ack fell while instr_req was high");

    commit_idle_after_reset: assert property (@(posedge in_clk)
        $fell(in_rst) |-> !commit_valid)
        else $error("commit_valid high right after reset");

endmodule

bind ooo_core ooo_core_chk u_chk (
    .in_clk       (in_clk),
    .in_rst       (in_rst),
    .instr_req    (instr_req),
    .instr_ack    (instr_ack),
    .commit_valid (commit_valid)
);

// File: testbench/ooo_core_tb.sv
`timescale 1ns/1ps
`include "ooo_defines.svh"

module ooo_core_tb;
    import ooo_pkg::*;

    typedef struct {
        alu_op_t                   op;
        logic [`GPR_IDX_WIDTH-1:0] dst;
        logic [`GPR_IDX_WIDTH-1:0] src1;
        logic [`GPR_IDX_WIDTH-1:0] src2;
        logic [`IMM_WIDTH-1:0]     imm;
        logic                      set_nzcv;
        logic                      burst;
        logic [`GPR_WIDTH-1:0]     exp_value;
        logic [3:0]                exp_nzcv;
    } instr_entry_t;

    logic                      in_clk;
    logic                      in_rst;
    logic                      instr_req;
    alu_op_t                   instr_op;
    logic [`GPR_IDX_WIDTH-1:0] instr_dst;
    logic [`GPR_IDX_WIDTH-1:0] instr_src1;
    logic [`GPR_IDX_WIDTH-1:0] instr_src2;
    logic [`IMM_WIDTH-1:0]     instr_imm;
    logic                      instr_set_nzcv;
    logic                      instr_ack;
    logic                      commit_valid;
    logic [`GPR_IDX_WIDTH-1:0] commit_gpr_idx;
    logic [`GPR_WIDTH-1:0]     commit_value;
    logic                      commit_nzcv_valid;
    nzcv_t                     commit_nzcv;
    logic [3:0]                got_nzcv;

    instr_entry_t          prog [64];
    logic [`GPR_WIDTH-1:0] model_regs [1 << `GPR_IDX_WIDTH];
    int                    num_instr = 0;
    int                    commit_count = 0;
    int                    cycle_count = 0;
    int                    timeout_limit = 0;

    assign got_nzcv = commit_nzcv;

    ooo_core uut (.*);

    initial begin
        in_clk = 1'b0;
        forever #2 in_clk = ~in_clk;
    end

    // Sequential reference model fills the expected columns
    task automatic add_instr(input alu_op_t op, input int dst, input int s1, input int s2,
                             input logic [`IMM_WIDTH-1:0] imm, input logic setf,
                             input logic burst);
        logic [`GPR_WIDTH-1:0] a;
        logic [`GPR_WIDTH-1:0] b;
        logic [`GPR_WIDTH-1:0] val;
        logic [`GPR_WIDTH-1:0] ovf;
        logic [`GPR_WIDTH:0]   wide;
        logic                  c;
        logic                  v;
        a   = model_regs[s1[`GPR_IDX_WIDTH-1:0]];
        b   = model_regs[s2[`GPR_IDX_WIDTH-1:0]];
        c   = 1'b0;
        v   = 1'b0;
        ovf = '0;
        case (op)
            ADD: begin
                wide = {1'b0, a} + {1'b0, b};
                val  = wide[`GPR_WIDTH-1:0];
                c    = wide[`GPR_WIDTH];
                ovf  = (a ^ val) & (b ^ val);
            end
            SUB: begin
                val = a - b;
                c   = (a >= b);
                ovf = (a ^ b) & (a ^ val);
            end
            AND:     val = a & b;
            ORR:     val = a | b;
            default: val = {{(`GPR_WIDTH - `IMM_WIDTH){1'b0}}, imm};
        endcase
        v = ovf[`GPR_WIDTH-1];
        model_regs[dst[`GPR_IDX_WIDTH-1:0]] = val;
        prog[num_instr].op        = op;
        prog[num_instr].dst       = dst[`GPR_IDX_WIDTH-1:0];
        prog[num_instr].src1      = s1[`GPR_IDX_WIDTH-1:0];
        prog[num_instr].src2      = s2[`GPR_IDX_WIDTH-1:0];
        prog[num_instr].imm       = imm;
        prog[num_instr].set_nzcv  = setf;
        prog[num_instr].burst     = burst;
        prog[num_instr].exp_value = val;
        prog[num_instr].exp_nzcv  = {val[`GPR_WIDTH-1], val == '0, c, v};
        num_instr++;
    endtask

    task automatic build_program();
        for (int r = 0; r < (1 << `GPR_IDX_WIDTH); r++)
            model_regs[r] = '0;
        // Load every register, high immediates check zero extension
        add_instr(MOVI, 0, 0, 0, 16'h0001, 1'b0, 1'b0);
        add_instr(MOVI, 1, 0, 0, 16'hffff, 1'b1, 1'b0);
        add_instr(MOVI, 2, 0, 0, 16'h8000, 1'b0, 1'b0);
        add_instr(MOVI, 3, 0, 0, 16'h0000, 1'b1, 1'b0);
        add_instr(MOVI, 4, 0, 0, 16'h1234, 1'b0, 1'b0);
        add_instr(MOVI, 5, 0, 0, 16'h00ff, 1'b0, 1'b0);
        add_instr(MOVI, 6, 0, 0, 16'h7fff, 1'b0, 1'b0);
        add_instr(MOVI, 7, 0, 0, 16'h0f0f, 1'b0, 1'b0);
        // Dependent chain
        add_instr(ADD, 3, 1, 4, 16'h0, 1'b1, 1'b0);
        add_instr(SUB, 5, 3, 5, 16'h0, 1'b1, 1'b0);
        add_instr(AND, 6, 5, 7, 16'h0, 1'b0, 1'b0);
        add_instr(ORR, 0, 6, 2, 16'h0, 1'b0, 1'b0);
        // Borrow, zero and carry out
        add_instr(SUB, 4, 5, 3, 16'h0, 1'b1, 1'b0);
        add_instr(SUB, 7, 3, 3, 16'h0, 1'b1, 1'b0);
        add_instr(ADD, 2, 4, 1, 16'h0, 1'b1, 1'b0);
        // Two writes to r6, the reader must see the second
        add_instr(MOVI, 6, 0, 0, 16'h0011, 1'b0, 1'b1);
        add_instr(MOVI, 6, 0, 0, 16'h0022, 1'b0, 1'b1);
        add_instr(ADD, 5, 6, 6, 16'h0, 1'b1, 1'b1);
        // Back-to-back doubling of r1 up to 0x7fff8000
        for (int k = 0; k < 15; k++)
            add_instr(ADD, 1, 1, 1, 16'h0, 1'b0, 1'b1);
        // Signed overflow on ADD and SUB
        add_instr(ADD, 2, 1, 1, 16'h0, 1'b1, 1'b1);
        add_instr(SUB, 3, 7, 1, 16'h0, 1'b1, 1'b0);
        add_instr(SUB, 4, 3, 1, 16'h0, 1'b1, 1'b0);
    endtask

    // Four-phase handshake for one table entry
    task automatic send_instr(input int i);
        int gap;
        gap = prog[i].burst ? 0 : int'($urandom % 4);
        repeat (gap) @(posedge in_clk);
        @(posedge in_clk);
        instr_req      <= 1'b1;
        instr_op       <= prog[i].op;
        instr_dst      <= prog[i].dst;
        instr_src1     <= prog[i].src1;
        instr_src2     <= prog[i].src2;
        instr_imm      <= prog[i].imm;
        instr_set_nzcv <= prog[i].set_nzcv;
        @(negedge in_clk);
        while (!instr_ack)
            @(negedge in_clk);
        @(posedge in_clk);
        instr_req <= 1'b0;
        @(negedge in_clk);
        while (instr_ack)
            @(negedge in_clk);
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("Error: time %0t, %s is %h, expected %h", $time, what, got, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "Commit mismatch");
        end
    endtask

    // Commit outputs are sampled mid-cycle
    always @(negedge in_clk) begin
        if (!in_rst && commit_valid) begin
            if (commit_count >= num_instr) begin
                $display("Error: time %0t, commit with no instruction left", $time);
                $display("SIMULATION FAILED");
                $fatal(1, "Unexpected commit");
            end else begin
                check_value("destination", 32'(commit_gpr_idx), 32'(prog[commit_count].dst));
                check_value("value", commit_value, prog[commit_count].exp_value);
                check_value("flag valid", 32'(commit_nzcv_valid),
                            32'(prog[commit_count].set_nzcv));
                if (prog[commit_count].set_nzcv)
                    check_value("nzcv", 32'(got_nzcv), 32'(prog[commit_count].exp_nzcv));
                commit_count++;
            end
        end
    end

    always @(posedge in_clk) begin
        cycle_count++;
        if (timeout_limit != 0 && cycle_count > timeout_limit) begin
            $display("Timeout: %0d of %0d commits seen after %0d cycles",
                     commit_count, num_instr, cycle_count);
            $display("SIMULATION FAILED");
            $fatal(1, "Timeout");
        end
    end

    initial begin
        in_rst         = 1'b1;
        instr_req      = 1'b0;
        instr_op       = MOVI;
        instr_dst      = '0;
        instr_src1     = '0;
        instr_src2     = '0;
        instr_imm      = '0;
        instr_set_nzcv = 1'b0;
        void'($urandom(32'h2edd));
        build_program();
        timeout_limit = 40 * num_instr + 100;
        repeat (4) @(posedge in_clk);
        in_rst <= 1'b0;
        @(negedge in_clk);
        for (int i = 0; i < num_instr; i++)
            send_instr(i);
        while (commit_count < num_instr)
            @(negedge in_clk);
        // Watch for stray commits
        repeat (10) @(negedge in_clk);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// File: sources.f
+incdir+include
verilog/ooo_pkg.sv
verilog/dispatch.sv
verilog/reservation_station.sv
verilog/alu_unit.sv
verilog/rob.sv
verilog/regfile.sv
verilog/ooo_core.sv
testbench/ooo_core_chk.sv
testbench/ooo_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the ooo_core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module ooo_core_tb \
    -f sources.f \
    -o ooo_core_tb

./obj_dir/ooo_core_tb
